// File: common/cargo_defines.svh
`ifndef CARGO_DEFINES_SVH
`define CARGO_DEFINES_SVH

// building and stop memory
`define FLOORS        4
`define QUEUE_DEPTH   8

// clock cycles per serial bit
`define BAUD_DIVIDER  16

// timed motion, no shaft sensors
`define TRAVEL_TICKS  40  // one floor
`define DOOR_TICKS    24  // door held open

`endif

// File: common/cargoPkg.sv
package cargoPkg;

    typedef logic [1:0] floorT;  // floor 0..3
    typedef logic [1:0] cargoT;
    typedef logic [3:0] qAddrT;  // holds a full count as well as an index

    // what the stop memory does this cycle
    typedef enum logic [1:0] {
        QOP_NONE,
        QOP_INSERT,
        QOP_POP
    } queueOpE;

endpackage

// File: common/ctrlPkg.sv
package ctrlPkg;

    // fitting a request into the stop queue
    typedef enum logic [2:0] {
        FIT_IDLE,
        FIT_CHECK,
        FIT_SCAN_ORIG,
        FIT_PUT_ORIG,
        FIT_SCAN_DEST,
        FIT_PUT_DEST
    } fitStateE;

    typedef enum logic [1:0] {
        MOT_PARKED,
        MOT_TRAVEL,
        MOT_DOOR
    } motionStateE;

endpackage

// File: serial/rxSerial8n1.sv
`timescale 1ns/1ps
`include "cargo_defines.svh"

module rxSerial8n1 (
    input  logic       clock,
    input  logic       rstN,
    input  logic       rx,
    output logic       byteReady,
    output logic [7:0] rxByte
);

    localparam int BAUD_W = $clog2(`BAUD_DIVIDER);
    localparam logic [BAUD_W-1:0] FULL_BIT = BAUD_W'(`BAUD_DIVIDER - 1);
    localparam logic [BAUD_W-1:0] HALF_BIT = BAUD_W'(`BAUD_DIVIDER / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rxStateE;

    rxStateE           state;
    logic [1:0]        rxSync;  // two-flop synchronizer
    logic [BAUD_W-1:0] baudCnt;
    logic [2:0]        bitCnt;
    logic [7:0]        shiftReg;
    logic              tick;
    logic              rxLine;

    assign rxLine = rxSync[1];
    assign tick   = (baudCnt == '0);
    assign rxByte = shiftReg;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            rxSync <= 2'b11;  // idle line is high
        end else begin
            rxSync <= {rxSync[0], rx};
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state     <= RX_IDLE;
            baudCnt   <= '0;
            bitCnt    <= '0;
            byteReady <= 1'b0;
        end else begin
            byteReady <= 1'b0;
            if (!tick) begin
                baudCnt <= baudCnt - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (!rxLine) begin
                        state   <= RX_START;
                        baudCnt <= HALF_BIT;  // aim at the middle of the start bit
                    end
                end
                RX_START: begin
                    if (tick) begin
                        state   <= rxLine ? RX_IDLE : RX_DATA;  // glitch check
                        baudCnt <= FULL_BIT;
                        bitCnt  <= '0;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        baudCnt <= FULL_BIT;
                        bitCnt  <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        byteReady <= rxLine;  // framing error drops the byte
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clock) begin
        if (state == RX_DATA && tick) begin
            shiftReg <= {rxLine, shiftReg[7:1]};
        end
    end

endmodule

// File: queue/stopQueue.sv
`timescale 1ns/1ps
`include "cargo_defines.svh"

module stopQueue (
    input  logic              clock,
    input  logic              rstN,
    input  cargoPkg::queueOpE queueOp,
    input  cargoPkg::qAddrT   insIndex,
    input  cargoPkg::floorT   insData,
    input  cargoPkg::qAddrT   scanIndex,
    output cargoPkg::floorT   headStop,
    output cargoPkg::floorT   curStop,
    output cargoPkg::floorT   prevStop,
    output cargoPkg::qAddrT   queueCount
);
    import cargoPkg::*;

    localparam int AW = $clog2(`QUEUE_DEPTH);
    localparam qAddrT DEPTH = qAddrT'(`QUEUE_DEPTH);

    floorT stops [`QUEUE_DEPTH];
    qAddrT count;
    qAddrT prevIndex;

    assign prevIndex  = scanIndex - 1'b1;  // wraps at 0, datapath uses the floor there
    assign queueCount = count;
    assign headStop   = stops[0];

    // reads past the top give 0
    assign curStop  = (scanIndex < DEPTH) ? stops[scanIndex[AW-1:0]] : '0;
    assign prevStop = (prevIndex < DEPTH) ? stops[prevIndex[AW-1:0]] : '0;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            count <= '0;
        end else begin
            case (queueOp)
                QOP_INSERT: count <= count + 1'b1;
                QOP_POP:    count <= count - 1'b1;
                default:    count <= count;
            endcase
        end
    end

    // entries at and above count are stale
    always_ff @(posedge clock) begin
        case (queueOp)
            QOP_INSERT: begin
                for (int i = `QUEUE_DEPTH - 1; i > 0; i--) begin
                    if (qAddrT'(i) > insIndex) begin
                        stops[i] <= stops[i-1];  // open a gap above the index
                    end
                end
                stops[insIndex[AW-1:0]] <= insData;
            end
            QOP_POP: begin
                for (int i = 0; i < `QUEUE_DEPTH - 1; i++) begin
                    stops[i] <= stops[i+1];
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/cargoDatapath.sv
`timescale 1ns/1ps
`include "cargo_defines.svh"

module cargoDatapath (
    input  logic            clock,
    input  logic            rstN,
    input  logic            byteReady,
    input  logic [7:0]      rxByte,
    input  logic            selDest,
    input  logic            scanClear,
    input  logic            scanStep,
    input  logic            floorStep,
    input  logic            floorUp,
    input  logic            timerRun,
    input  logic            doorPhase,
    input  cargoPkg::floorT headStop,
    input  cargoPkg::floorT curStop,
    input  cargoPkg::floorT prevStop,
    input  cargoPkg::qAddrT queueCount,
    output logic            newRequest,
    output cargoPkg::qAddrT scanIndex,
    output cargoPkg::floorT candidate,
    output logic            between,
    output logic            repeated,
    output logic            atEnd,
    output cargoPkg::floorT floor,
    output logic            headAbove,
    output logic            atHead,
    output logic            timerDone,
    output cargoPkg::cargoT cargoType
);
    import cargoPkg::*;

    localparam int MAX_TICKS = (`TRAVEL_TICKS > `DOOR_TICKS) ? `TRAVEL_TICKS : `DOOR_TICKS;
    localparam int TIMER_W = $clog2(MAX_TICKS);
    localparam floorT TOP_FLOOR = floorT'(`FLOORS - 1);

    floorT              origin;
    floorT              dest;
    floorT              prevPoint;
    logic               readyDly;
    logic [TIMER_W-1:0] timer;
    logic [TIMER_W-1:0] timerLast;

    // request byte: [1:0] origin, [3:2] destination, [5:4] cargo
    always_ff @(posedge clock) begin
        if (byteReady) begin
            origin    <= rxByte[1:0];
            dest      <= rxByte[3:2];
            cargoType <= rxByte[5:4];
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            readyDly   <= 1'b0;
            newRequest <= 1'b0;
        end else begin
            readyDly   <= byteReady;
            newRequest <= byteReady & ~readyDly;  // rising edge, a cycle after the latch
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN || scanClear) begin
            scanIndex <= '0;
        end else if (scanStep) begin
            scanIndex <= scanIndex + 1'b1;
        end
    end

    // comparisons for the ride-along rule
    assign candidate = selDest ? dest : origin;
    assign prevPoint = (scanIndex == '0) ? floor : prevStop;
    assign atEnd     = (scanIndex == queueCount);

    always_comb begin
        between = ((candidate > prevPoint) && (candidate < curStop)) ||
                  ((candidate < prevPoint) && (candidate > curStop));
        between = between && !atEnd;  // no next point past the end
        repeated = (candidate == prevPoint) || (!atEnd && (candidate == curStop));
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            floor <= '0;
        end else if (floorStep) begin
            if (floorUp && floor != TOP_FLOOR) begin
                floor <= floor + 1'b1;
            end else if (!floorUp && floor != '0) begin
                floor <= floor - 1'b1;
            end
        end
    end

    assign headAbove = (headStop > floor);
    assign atHead    = (headStop == floor);

    // one timer shared by travel and door
    assign timerLast = doorPhase ? TIMER_W'(`DOOR_TICKS - 1) : TIMER_W'(`TRAVEL_TICKS - 1);
    assign timerDone = timerRun && (timer == timerLast);

    always_ff @(posedge clock) begin
        if (!rstN || !timerRun || timerDone) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

endmodule

// File: hdl/cargoControl.sv
`timescale 1ns/1ps
`include "cargo_defines.svh"

module cargoControl (
    input  logic              clock,
    input  logic              rstN,
    input  logic              newRequest,
    input  logic              between,
    input  logic              repeated,
    input  logic              atEnd,
    input  cargoPkg::qAddrT   queueCount,
    input  logic              headAbove,
    input  logic              atHead,
    input  logic              timerDone,
    output logic              selDest,
    output logic              scanClear,
    output logic              scanStep,
    output cargoPkg::queueOpE queueOp,
    output logic              floorStep,
    output logic              floorUp,
    output logic              timerRun,
    output logic              doorPhase,
    output logic              moving,
    output logic              doorOpen,
    output logic              stopServed,
    output logic              reqDropped
);
    import cargoPkg::*;
    import ctrlPkg::*;

    fitStateE    fitState;
    fitStateE    fitNext;
    motionStateE motState;
    motionStateE motNext;
    logic        doorExpired;  // door time over, pop still pending
    logic        insertNow;
    logic        popNow;
    logic        fitIdle;
    logic        queueFull;

    assign fitIdle   = (fitState == FIT_IDLE);
    assign queueFull = (queueCount + qAddrT'(2)) > qAddrT'(`QUEUE_DEPTH);  // room for both stops
    assign queueOp   = insertNow ? QOP_INSERT : (popNow ? QOP_POP : QOP_NONE);
    assign moving    = (motState == MOT_TRAVEL);
    assign doorOpen  = (motState == MOT_DOOR);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            fitState    <= FIT_IDLE;
            motState    <= MOT_PARKED;
            doorExpired <= 1'b0;
        end else begin
            fitState    <= fitNext;
            motState    <= motNext;
            doorExpired <= doorOpen && !popNow && (doorExpired || timerDone);
        end
    end

    // fit FSM, one scan position per cycle
    always_comb begin
        fitNext    = fitState;
        selDest    = 1'b0;
        scanClear  = 1'b0;
        scanStep   = 1'b0;
        insertNow  = 1'b0;
        reqDropped = 1'b0;
        case (fitState)
            FIT_IDLE: begin
                if (newRequest) begin
                    fitNext = FIT_CHECK;
                end
            end
            FIT_CHECK: begin
                if (queueFull) begin
                    reqDropped = 1'b1;
                    fitNext    = FIT_IDLE;
                end else begin
                    scanClear = 1'b1;
                    fitNext   = FIT_SCAN_ORIG;
                end
            end
            FIT_SCAN_ORIG: begin
                if (repeated) begin
                    // a match on the next point puts the destination scan past it
                    scanStep = !atEnd;
                    fitNext  = FIT_SCAN_DEST;
                end else if (between || atEnd) begin
                    fitNext = FIT_PUT_ORIG;
                end else begin
                    scanStep = 1'b1;
                end
            end
            FIT_PUT_ORIG: begin
                insertNow = 1'b1;
                scanStep  = 1'b1;  // destination must come after the origin
                fitNext   = FIT_SCAN_DEST;
            end
            FIT_SCAN_DEST: begin
                selDest = 1'b1;
                if (repeated) begin
                    fitNext = FIT_IDLE;
                end else if (between || atEnd) begin
                    fitNext = FIT_PUT_DEST;
                end else begin
                    scanStep = 1'b1;
                end
            end
            FIT_PUT_DEST: begin
                selDest   = 1'b1;
                insertNow = 1'b1;
                fitNext   = FIT_IDLE;
            end
            default: fitNext = FIT_IDLE;
        endcase
    end

    // motion FSM
    always_comb begin
        motNext    = motState;
        floorStep  = 1'b0;
        floorUp    = 1'b0;
        timerRun   = 1'b0;
        doorPhase  = 1'b0;
        popNow     = 1'b0;
        stopServed = 1'b0;
        case (motState)
            MOT_PARKED: begin
                if (queueCount != '0) begin
                    motNext = atHead ? MOT_DOOR : MOT_TRAVEL;
                end
            end
            MOT_TRAVEL: begin
                if (atHead) begin
                    motNext = MOT_DOOR;
                end else begin
                    timerRun  = 1'b1;
                    floorStep = timerDone;  // one floor per travel period
                    floorUp   = headAbove;
                end
            end
            MOT_DOOR: begin
                doorPhase = 1'b1;
                timerRun  = !doorExpired;
                // queue belongs to the fit FSM until it is idle
                if ((doorExpired || timerDone) && fitIdle) begin
                    popNow     = 1'b1;
                    stopServed = 1'b1;
                    motNext    = MOT_PARKED;
                end
            end
            default: motNext = MOT_PARKED;
        endcase
    end

endmodule

// File: hdl/smartCargo.sv
`timescale 1ns/1ps

module smartCargo (
    input  logic            clock,
    input  logic            rstN,
    input  logic            rx,
    output cargoPkg::floorT floor,
    output logic            moving,
    output logic            doorOpen,
    output logic            stopServed,
    output cargoPkg::floorT servedFloor,
    output logic            reqDropped,
    output cargoPkg::cargoT cargoType
);
    import cargoPkg::*;

    logic       byteReady;
    logic [7:0] rxByte;
    logic       newRequest;
    logic       selDest;
    logic       scanClear;
    logic       scanStep;
    logic       between;
    logic       repeated;
    logic       atEnd;
    logic       floorStep;
    logic       floorUp;
    logic       timerRun;
    logic       doorPhase;
    logic       timerDone;
    logic       headAbove;
    logic       atHead;
    queueOpE    queueOp;
    qAddrT      scanIndex;
    qAddrT      queueCount;
    floorT      candidate;
    floorT      headStop;
    floorT      curStop;
    floorT      prevStop;

    assign servedFloor = floor;  // sampled by stopServed

    rxSerial8n1 rxUnit (
        .clock     (clock),
        .rstN      (rstN),
        .rx        (rx),
        .byteReady (byteReady),
        .rxByte    (rxByte)
    );

    cargoDatapath dp (
        .clock      (clock),
        .rstN       (rstN),
        .byteReady  (byteReady),
        .rxByte     (rxByte),
        .selDest    (selDest),
        .scanClear  (scanClear),
        .scanStep   (scanStep),
        .floorStep  (floorStep),
        .floorUp    (floorUp),
        .timerRun   (timerRun),
        .doorPhase  (doorPhase),
        .headStop   (headStop),
        .curStop    (curStop),
        .prevStop   (prevStop),
        .queueCount (queueCount),
        .newRequest (newRequest),
        .scanIndex  (scanIndex),
        .candidate  (candidate),
        .between    (between),
        .repeated   (repeated),
        .atEnd      (atEnd),
        .floor      (floor),
        .headAbove  (headAbove),
        .atHead     (atHead),
        .timerDone  (timerDone),
        .cargoType  (cargoType)
    );

    stopQueue queue (
        .clock      (clock),
        .rstN       (rstN),
        .queueOp    (queueOp),
        .insIndex   (scanIndex),  // inserts land at the scan position
        .insData    (candidate),
        .scanIndex  (scanIndex),
        .headStop   (headStop),
        .curStop    (curStop),
        .prevStop   (prevStop),
        .queueCount (queueCount)
    );

    cargoControl ctrl (
        .clock      (clock),
        .rstN       (rstN),
        .newRequest (newRequest),
        .between    (between),
        .repeated   (repeated),
        .atEnd      (atEnd),
        .queueCount (queueCount),
        .headAbove  (headAbove),
        .atHead     (atHead),
        .timerDone  (timerDone),
        .selDest    (selDest),
        .scanClear  (scanClear),
        .scanStep   (scanStep),
        .queueOp    (queueOp),
        .floorStep  (floorStep),
        .floorUp    (floorUp),
        .timerRun   (timerRun),
        .doorPhase  (doorPhase),
        .moving     (moving),
        .doorOpen   (doorOpen),
        .stopServed (stopServed),
        .reqDropped (reqDropped)
    );

endmodule

// File: dv/smartCargoTb.sv
`timescale 1ns/1ps
`include "cargo_defines.svh"

module smartCargoTb;
    import cargoPkg::*;

    localparam int SEED = 32'h27c5245d;
    localparam int RANDOM_FRAMES = 40;
    localparam int FIXED_FRAMES = 16;
    localparam int FRAME_CYCLES = 10 * `BAUD_DIVIDER;
    localparam int SERVE_CYCLES =
        `QUEUE_DEPTH * ((`FLOORS - 1) * (`TRAVEL_TICKS + 1) + `DOOR_TICKS + 4);
    localparam int LIMIT_CYCLES =
        (RANDOM_FRAMES + FIXED_FRAMES) * (FRAME_CYCLES + 300 + SERVE_CYCLES) + 2000;

    logic  clock;
    logic  rstN;
    logic  rx;
    floorT floor;
    logic  moving;
    logic  doorOpen;
    logic  stopServed;
    floorT servedFloor;
    logic  reqDropped;
    cargoT cargoType;

    floorT      stopModel[$];   // reference stop queue
    floorT      expServed;
    logic       underflow;
    logic       expDrop;
    cargoT      lastCargo;
    logic       validSeen;
    logic       busy;           // a frame is on the line
    logic [7:0] reqByte;        // last frame sent with a good stop bit
    int         reqPhase;
    int         destStart;
    int         served;
    int         inserted;
    int         goodFrames;
    int         requests;

    smartCargo uut (
        .clock       (clock),
        .rstN        (rstN),
        .rx          (rx),
        .floor       (floor),
        .moving      (moving),
        .doorOpen    (doorOpen),
        .stopServed  (stopServed),
        .servedFloor (servedFloor),
        .reqDropped  (reqDropped),
        .cargoType   (cargoType)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stopOnError();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // ride-along rule, returns where the next scan starts
    function automatic int placeStop(floorT cand, int start, floorT here);
        floorT prev;
        int    i;
        int    next;
        bit    placed;
        i      = start;
        next   = start;
        placed = 1'b0;
        while (!placed) begin
            prev = (i == 0) ? here : stopModel[i-1];
            if (i == stopModel.size()) begin
                next = i;
                if (cand != prev) begin
                    stopModel.push_back(cand);
                    inserted++;
                    next = i + 1;
                end
                placed = 1'b1;
            end else if (cand == prev || cand == stopModel[i]) begin
                next   = i + 1;  // repeat, skip past the match
                placed = 1'b1;
            end else if ((cand > prev && cand < stopModel[i]) ||
                         (cand < prev && cand > stopModel[i])) begin
                stopModel.insert(i, cand);
                inserted++;
                next   = i + 1;
                placed = 1'b1;
            end else begin
                i++;
            end
        end
        return next;
    endfunction

    task automatic sendFrame(input logic [7:0] data, input logic goodStop);
        busy = 1'b1;
        rx = 1'b0;
        repeat (`BAUD_DIVIDER) @(negedge clock);
        for (int b = 0; b < 8; b++) begin
            rx = data[b];
            repeat (`BAUD_DIVIDER) @(negedge clock);
        end
        if (goodStop) begin
            reqByte = data;  // model fits it once the request is seen
            rx = 1'b1;
            repeat (`BAUD_DIVIDER) @(negedge clock);
            lastCargo = data[5:4];
            validSeen = 1'b1;
            goodFrames++;
        end else begin
            rx = 1'b0;  // framing error, released early so no false start follows
            repeat (12) @(negedge clock);
            rx = 1'b1;
            repeat (2 * `BAUD_DIVIDER) @(negedge clock);
        end
        busy = 1'b0;
    endtask

    // model runs mid-cycle where DUT values are settled
    always @(negedge clock) begin
        expDrop = 1'b0;
        if (!rstN) begin
            reqPhase = 0;
        end else begin
            if (stopServed) begin
                served++;
                underflow = (stopModel.size() == 0);
                if (!underflow) begin
                    expServed = stopModel.pop_front();
                end
            end
            if (reqPhase == 1) begin
                expDrop  = (stopModel.size() > `QUEUE_DEPTH - 2);
                reqPhase = expDrop ? 0 : 2;
            end else if (reqPhase == 2) begin
                destStart = placeStop(reqByte[1:0], 0, floor);
                void'(placeStop(reqByte[3:2], destStart, floor));
                reqPhase = 0;
            end
            if (uut.newRequest) begin
                requests++;
                reqPhase = 1;
            end
        end
    end

    // checks
    servedHead: assert property (@(posedge clock) disable iff (!rstN)
        stopServed |-> (!underflow && servedFloor == expServed))
        else begin
            $display("ERR servedFloor got %h exp %h", servedFloor, expServed);
            stopOnError();
        end
    floorSteps: assert property (@(posedge clock) disable iff (!rstN)
        $changed(floor) |-> ($past(moving) &&
            ((int'(floor) == int'($past(floor)) + 1) || (int'(floor) == int'($past(floor)) - 1))))
        else begin
            $display("ERR floor now %h, moving before was %h", floor, $past(moving));
            stopOnError();
        end
    doorNotMoving: assert property (@(posedge clock) disable iff (!rstN) !(doorOpen && moving))
        else begin
            $display("ERR doorOpen %h moving %h", doorOpen, moving);
            stopOnError();
        end
    doorBeforeServe: assert property (@(posedge clock) disable iff (!rstN)
        stopServed |-> $past(doorOpen))
        else begin
            $display("ERR doorOpen %h before stopServed", $past(doorOpen));
            stopOnError();
        end
    dropPulse: assert property (@(posedge clock) disable iff (!rstN) reqDropped == expDrop)
        else begin
            $display("ERR reqDropped got %h exp %h", reqDropped, expDrop);
            stopOnError();
        end
    requestTaken: assert property (@(posedge clock) disable iff (!rstN)
        !busy |-> requests == goodFrames)
        else begin
            $display("ERR requests got %h exp %h", requests, goodFrames);
            stopOnError();
        end
    parkedWhenEmpty: assert property (@(posedge clock) disable iff (!rstN)
        (stopModel.size() == 0 && !stopServed) |-> (!moving && !doorOpen))
        else begin
            $display("ERR moving %h doorOpen %h with empty queue", moving, doorOpen);
            stopOnError();
        end
    cargoHeld: assert property (@(posedge clock) disable iff (!rstN)
        (!busy && validSeen) |-> cargoType == lastCargo)
        else begin
            $display("ERR cargoType got %h exp %h", cargoType, lastCargo);
            stopOnError();
        end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish in %0d cycles", LIMIT_CYCLES);
        stopOnError();
    end

    initial begin
        logic [7:0] burst[10];
        burst = '{8'h0C, 8'h31, 8'h23, 8'h09, 8'h16, 8'h3C, 8'h21, 8'h0E, 8'h34, 8'h1B};
        void'($urandom(SEED));
        rx = 1'b1;
        rstN = 1'b0;
        busy = 1'b0;
        validSeen = 1'b0;
        lastCargo = '0;
        reqByte = '0;
        underflow = 1'b0;
        expServed = '0;
        served = 0;
        inserted = 0;
        goodFrames = 0;
        requests = 0;
        repeat (8) @(negedge clock);
        rstN = 1'b1;
        repeat (20) @(negedge clock);

        sendFrame(8'h00, 1'b1);  // origin equals destination and floor
        sendFrame(8'h1D, 1'b1);
        sendFrame(8'h36, 1'b0);  // bad stop bit
        sendFrame(8'h27, 1'b1);
        repeat (800) @(negedge clock);
        sendFrame(8'h15, 1'b1);
        sendFrame(8'h3A, 1'b0);
        for (int k = 0; k < 10; k++) begin
            sendFrame(burst[k], 1'b1);  // back to back to fill the queue
        end

        for (int k = 0; k < RANDOM_FRAMES; k++) begin
            sendFrame(8'($urandom), ($urandom % 8) != 0);
            repeat ($urandom % 300) @(negedge clock);
        end

        while (stopModel.size() != 0 || moving || doorOpen) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);
        emptyAtEnd: assert (uut.queueCount == 0 && served == inserted) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("ERR queueCount %h served %h inserted %h",
                     uut.queueCount, served, inserted);
            stopOnError();
        end
    end

endmodule

// File: files.f
+incdir+common
common/cargoPkg.sv
common/ctrlPkg.sv
serial/rxSerial8n1.sv
queue/stopQueue.sv
hdl/cargoDatapath.sv
hdl/cargoControl.sv
hdl/smartCargo.sv
dv/smartCargoTb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = smartCargoTb
FLIST = files.f

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
